//--- all.f
rtl/gamePkg.sv
rtl/vgaTiming.sv
rtl/rectDrawer.sv
rtl/backgroundDrawer.sv
rtl/objectsMux.sv
rtl/gameDisplayTop.sv
sim/gameDisplayTb.sv

//--- rtl/backgroundDrawer.sv
// background layer
// answers every visible pixel with a border, a grid line or the plain field
// colour, registered once like the object drawers

`timescale 1ns/1ps

module backgroundDrawer (
	input  logic               clk,
	input  logic               resetN,
	input  gamePkg::pixelPos_t pos,
	output gamePkg::drawReq_t  drawReq
);

	import gamePkg::*;

	logic       onBorder;
	logic       onGrid;
	logic [7:0] pixelColor;

	// within BORDER_WIDTH of any of the four screen edges
	assign onBorder = (pos.x < BORDER_WIDTH) ||
		(pos.x >= H_VISIBLE - BORDER_WIDTH) ||
		(pos.y < BORDER_WIDTH) ||
		(pos.y >= V_VISIBLE - BORDER_WIDTH);

	assign onGrid = ((pos.x % GRID_STEP) == 0) || ((pos.y % GRID_STEP) == 0);

	always_comb begin
		if (onBorder)
			pixelColor = BORDER_COLOR;
		else if (onGrid)
			pixelColor = GRID_COLOR;
		else
			pixelColor = FIELD_COLOR;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			drawReq <= '0;
		end else begin
			drawReq.request <= pos.visible;
			drawReq.rgb     <= pos.visible ? pixelColor : 8'h00;
		end
	end

endmodule

//--- rtl/gameDisplayTop.sv
// display path top level
// timing generator feeds the player, prize and background drawers,
// whose requests the mux turns into 24-bit colour with aligned syncs

`timescale 1ns/1ps

module gameDisplayTop (
	input  logic                            clk,
	input  logic                            resetN,
	input  logic [gamePkg::COORD_WIDTH-1:0] playerX,
	input  logic [gamePkg::COORD_WIDTH-1:0] playerY,
	input  logic [gamePkg::COORD_WIDTH-1:0] prizeX,
	input  logic [gamePkg::COORD_WIDTH-1:0] prizeY,
	output gamePkg::rgb24_t                 rgbOut,
	output logic                            hSync,
	output logic                            vSync
);

	import gamePkg::*;

	pixelPos_t pos;
	logic      hSyncRaw;
	logic      vSyncRaw;
	drawReq_t  playerReq;
	drawReq_t  prizeReq;
	drawReq_t  backgroundReq;

	vgaTiming i_timing (
		.clk    (clk),
		.resetN (resetN),
		.pos    (pos),
		.hSync  (hSyncRaw),
		.vSync  (vSyncRaw)
	);

	rectDrawer #(
		.WIDTH  (32),
		.HEIGHT (32),
		.COLOR  (PLAYER_COLOR)
	) i_player (
		.clk      (clk),
		.resetN   (resetN),
		.pos      (pos),
		.topLeftX (playerX),
		.topLeftY (playerY),
		.drawReq  (playerReq)
	);

	rectDrawer #(
		.WIDTH  (16),
		.HEIGHT (16),
		.COLOR  (PRIZE_COLOR)
	) i_prize (
		.clk      (clk),
		.resetN   (resetN),
		.pos      (pos),
		.topLeftX (prizeX),
		.topLeftY (prizeY),
		.drawReq  (prizeReq)
	);

	backgroundDrawer i_background (
		.clk     (clk),
		.resetN  (resetN),
		.pos     (pos),
		.drawReq (backgroundReq)
	);

	objectsMux i_mux (
		.clk           (clk),
		.resetN        (resetN),
		.playerReq     (playerReq),
		.prizeReq      (prizeReq),
		.backgroundReq (backgroundReq),
		.hSyncIn       (hSyncRaw),
		.vSyncIn       (vSyncRaw),
		.rgbOut        (rgbOut),
		.hSync         (hSync),
		.vSync         (vSync)
	);

endmodule

//--- rtl/gamePkg.sv
// shared definitions for the raster display path
// screen timing, RGB332 colour constants and the pixel/request/colour structs
// every display module imports this package

package gamePkg;

	// 640x480 at 60 Hz, horizontal timing in pixel clocks
	localparam int H_VISIBLE = 640;
	localparam int H_FRONT   = 16;
	localparam int H_SYNC    = 96;
	localparam int H_BACK    = 48;
	localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

	// vertical timing in lines
	localparam int V_VISIBLE = 480;
	localparam int V_FRONT   = 10;
	localparam int V_SYNC    = 2;
	localparam int V_BACK    = 33;
	localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

	// clocks from a coordinate leaving the timing generator to its colour at the pins
	localparam int PIPE_DELAY = 2;

	// width of one screen coordinate
	localparam int COORD_WIDTH = 10;

	// RGB332 colours, red 7:5, green 4:2, blue 1:0
	localparam logic [7:0] BORDER_COLOR = 8'b101_101_10;
	localparam logic [7:0] GRID_COLOR   = 8'b010_100_01;
	localparam logic [7:0] FIELD_COLOR  = 8'b000_001_01;
	localparam logic [7:0] PLAYER_COLOR = 8'b111_110_00;
	localparam logic [7:0] PRIZE_COLOR  = 8'b111_000_11;

	// background geometry in pixels
	localparam int BORDER_WIDTH = 8;
	localparam int GRID_STEP    = 32;

	// current pixel as seen by every drawer
	typedef struct packed {
		logic [COORD_WIDTH-1:0] x;
		logic [COORD_WIDTH-1:0] y;
		logic                   visible;
	} pixelPos_t;

	// one object's answer for the current pixel
	typedef struct packed {
		logic       request;
		logic [7:0] rgb;
	} drawReq_t;

	// colour at the output pins
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb24_t;

	// source that won a pixel
	typedef enum logic [1:0] {
		layerPlayer,
		layerPrize,
		layerBackground,
		layerBlank
	} layer_t;

endpackage

//--- rtl/objectsMux.sv
// priority mux for the drawing layers
// player beats prize beats background, black when nobody asks
// the winner is expanded from RGB332 to 24 bits and registered, and the
// raw sync bits are delayed to line up with the colour

`timescale 1ns/1ps

module objectsMux (
	input  logic              clk,
	input  logic              resetN,
	input  gamePkg::drawReq_t playerReq,
	input  gamePkg::drawReq_t prizeReq,
	input  gamePkg::drawReq_t backgroundReq,
	input  logic              hSyncIn,
	input  logic              vSyncIn,
	output gamePkg::rgb24_t   rgbOut,
	output logic              hSync,
	output logic              vSync
);

	import gamePkg::*;

	layer_t                winner;
	logic [7:0]            winnerRgb;
	logic [PIPE_DELAY-1:0] hSyncPipe;
	logic [PIPE_DELAY-1:0] vSyncPipe;

	// low bits of each channel repeat the field lsb
	function automatic rgb24_t expand332(input logic [7:0] c);
		rgb24_t e;
		e.red   = {c[7:5], {5{c[5]}}};
		e.green = {c[4:2], {5{c[2]}}};
		e.blue  = {c[1:0], {6{c[0]}}};
		return e;
	endfunction

	always_comb begin
		if (playerReq.request) begin
			winner    = layerPlayer;
			winnerRgb = playerReq.rgb;
		end else if (prizeReq.request) begin
			winner    = layerPrize;
			winnerRgb = prizeReq.rgb;
		end else if (backgroundReq.request) begin
			winner    = layerBackground;
			winnerRgb = backgroundReq.rgb;
		end else begin
			winner    = layerBlank;
			winnerRgb = 8'h00;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			rgbOut <= '0;
		end else if (winner == layerBlank) begin
			rgbOut <= '0;
		end else begin
			rgbOut <= expand332(winnerRgb);
		end
	end

	// sync bits come straight from the timing generator, so they need the
	// drawer stage plus this stage to match the colour
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hSyncPipe <= '1;
			vSyncPipe <= '1;
		end else begin
			hSyncPipe <= {hSyncPipe[PIPE_DELAY-2:0], hSyncIn};
			vSyncPipe <= {vSyncPipe[PIPE_DELAY-2:0], vSyncIn};
		end
	end

	assign hSync = hSyncPipe[PIPE_DELAY-1];
	assign vSync = vSyncPipe[PIPE_DELAY-1];

	// objects never draw where the background is silent, i.e. off screen
	noObjectOffScreen: assert property (
		@(posedge clk) disable iff (!resetN)
		!backgroundReq.request |-> (winner == layerBlank)
	);

endmodule

//--- rtl/rectDrawer.sv
// solid rectangle drawer
// requests its colour for every visible pixel inside the box that
// starts at topLeft and spans WIDTH x HEIGHT pixels, one clock of latency

`timescale 1ns/1ps

module rectDrawer #(
	parameter int         WIDTH  = 32,
	parameter int         HEIGHT = 32,
	parameter logic [7:0] COLOR  = 8'hFF
) (
	input  logic                            clk,
	input  logic                            resetN,
	input  gamePkg::pixelPos_t              pos,
	input  logic [gamePkg::COORD_WIDTH-1:0] topLeftX,
	input  logic [gamePkg::COORD_WIDTH-1:0] topLeftY,
	output gamePkg::drawReq_t               drawReq
);

	import gamePkg::*;

	logic insideX;
	logic insideY;
	logic hit;

	// half-open box, int sizes keep the sum from wrapping
	assign insideX = (pos.x >= topLeftX) && (pos.x < topLeftX + WIDTH);
	assign insideY = (pos.y >= topLeftY) && (pos.y < topLeftY + HEIGHT);
	assign hit     = pos.visible && insideX && insideY;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			drawReq <= '0;
		end else begin
			drawReq.request <= hit;
			// colour only meaningful with the request
			drawReq.rgb     <= hit ? COLOR : 8'h00;
		end
	end

endmodule

//--- rtl/vgaTiming.sv
// VGA timing generator for the 640x480 screen
// walks the raster one pixel per clock and registers the coordinate,
// the visible flag and both active-low sync levels together

`timescale 1ns/1ps

module vgaTiming (
	input  logic               clk,
	input  logic               resetN,
	output gamePkg::pixelPos_t pos,
	output logic               hSync,
	output logic               vSync
);

	import gamePkg::*;

	logic [COORD_WIDTH-1:0] hCount;
	logic [COORD_WIDTH-1:0] vCount;
	logic                   lineEnd;
	logic                   hSyncNext;
	logic                   vSyncNext;

	assign lineEnd = (hCount == H_TOTAL - 1);

	// sync pulses are low inside the sync window
	assign hSyncNext = !((hCount >= H_VISIBLE + H_FRONT) &&
		(hCount < H_VISIBLE + H_FRONT + H_SYNC));
	assign vSyncNext = !((vCount >= V_VISIBLE + V_FRONT) &&
		(vCount < V_VISIBLE + V_FRONT + V_SYNC));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			if (lineEnd) begin
				hCount <= '0;
				// last line of the frame wraps the vertical count too
				if (vCount == V_TOTAL - 1)
					vCount <= '0;
				else
					vCount <= vCount + 1'b1;
			end else begin
				hCount <= hCount + 1'b1;
			end
		end
	end

	// output stage, everything leaves in the same clock
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pos   <= '0;
			hSync <= 1'b1;
			vSync <= 1'b1;
		end else begin
			pos.x       <= hCount;
			pos.y       <= vCount;
			pos.visible <= (hCount < H_VISIBLE) && (vCount < V_VISIBLE);
			hSync       <= hSyncNext;
			vSync       <= vSyncNext;
		end
	end

	hCountInRange: assert property (
		@(posedge clk) disable iff (!resetN)
		hCount < H_TOTAL
	);

	// vertical sync edges only at the first pixel of a line
	vSyncAtLineStart: assert property (
		@(posedge clk) disable iff (!resetN)
		$changed(vSync) |-> (pos.x == 0)
	);

endmodule

//--- run.sh
#!/bin/sh
# builds the display path testbench with Verilator and runs it
# exit status is non-zero when the build, the run or any check fails

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module gameDisplayTb -Mdir "$OBJ" -f all.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/VgameDisplayTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	echo "FAIL"
	exit 1
fi

if ! grep -q "All checks passed" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

echo "PASS"
exit 0

//--- sim/gameDisplayTb.sv
// testbench for the raster display path
// drives random player and prize positions during vertical blanking, tracks
// the screen position from the output syncs and checks every output pixel
// against a reference colour built from the screen rules

`timescale 1ns/1ps

module gameDisplayTb;

	import gamePkg::*;

	localparam int FRAME_CLOCKS  = H_TOTAL * V_TOTAL;
	localparam int FRAME_TIMEOUT = 2 * FRAME_CLOCKS;
	localparam int FRAMES        = 6;

	logic                   clk;
	logic                   resetN;
	logic [COORD_WIDTH-1:0] playerX;
	logic [COORD_WIDTH-1:0] playerY;
	logic [COORD_WIDTH-1:0] prizeX;
	logic [COORD_WIDTH-1:0] prizeY;
	rgb24_t                 rgbOut;
	logic                   hSync;
	logic                   vSync;

	// screen position of the pixel currently on the outputs
	int          curX;
	int          curY;
	logic        locked;
	logic        hSyncPrev;
	logic        vSyncPrev;
	logic [23:0] expectedRgb;
	logic        refVisible;

	// sync pulse measurements
	int   hLowLen;
	int   hPeriod;
	logic hFallSeen;
	int   vLowLen;
	int   vPeriod;
	logic vFallSeen;

	int hSyncErrors;
	int vSyncErrors;
	int blankErrors;
	int colourErrors;
	int expansionErrors;

	gameDisplayTop i_dut (
		.clk     (clk),
		.resetN  (resetN),
		.playerX (playerX),
		.playerY (playerY),
		.prizeX  (prizeX),
		.prizeY  (prizeY),
		.rgbOut  (rgbOut),
		.hSync   (hSync),
		.vSync   (vSync)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// RGB332 to 24 bits, low bits filled with the field lsb
	function automatic logic [23:0] expandColor(input logic [7:0] c);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		r = {c[7:5], 5'b00000};
		g = {c[4:2], 5'b00000};
		b = {c[1:0], 6'b000000};
		if (c[5])
			r = r | 8'h1f;
		if (c[2])
			g = g | 8'h1f;
		if (c[0])
			b = b | 8'h3f;
		return {r, g, b};
	endfunction

	function automatic logic insideBox(input int x, input int y, input int left,
		input int top, input int width, input int height);
		return (x >= left) && (x < left + width) && (y >= top) && (y < top + height);
	endfunction

	function automatic logic [23:0] referenceColor(input int x, input int y,
		input int plX, input int plY, input int prX, input int prY);
		if (x >= H_VISIBLE || y >= V_VISIBLE)
			return 24'h000000;
		if (insideBox(x, y, plX, plY, 32, 32))
			return expandColor(PLAYER_COLOR);
		if (insideBox(x, y, prX, prY, 16, 16))
			return expandColor(PRIZE_COLOR);
		if (x < BORDER_WIDTH || x >= H_VISIBLE - BORDER_WIDTH ||
			y < BORDER_WIDTH || y >= V_VISIBLE - BORDER_WIDTH)
			return expandColor(BORDER_COLOR);
		if ((x % GRID_STEP) == 0 || (y % GRID_STEP) == 0)
			return expandColor(GRID_COLOR);
		return expandColor(FIELD_COLOR);
	endfunction

	// low bits of every channel must all equal the field lsb
	function automatic logic expansionOk(input rgb24_t v);
		return (v.red[4:0] == (v.red[5] ? 5'h1f : 5'h00)) &&
			(v.green[4:0] == (v.green[5] ? 5'h1f : 5'h00)) &&
			(v.blue[5:0] == (v.blue[6] ? 6'h3f : 6'h00));
	endfunction

	assign refVisible  = locked && (curX < H_VISIBLE) && (curY < V_VISIBLE);
	assign expectedRgb = referenceColor(curX, curY, int'(playerX), int'(playerY),
		int'(prizeX), int'(prizeY));

	// position tracker, resynced on the output sync falls
	always @(posedge clk or negedge resetN) begin
		int px;
		int py;
		if (!resetN) begin
			curX      <= 0;
			curY      <= 0;
			locked    <= 1'b0;
			hSyncPrev <= 1'b1;
			vSyncPrev <= 1'b1;
		end else begin
			px = curX;
			py = curY;
			if (vSyncPrev && !vSync) begin
				px = 0;
				py = V_VISIBLE + V_FRONT;
				locked <= 1'b1;
			end else if (hSyncPrev && !hSync) begin
				// hSync falls H_SYNC + H_BACK clocks before the line wraps
				px = H_TOTAL - H_SYNC - H_BACK;
			end
			if (px == H_TOTAL - 1) begin
				curX <= 0;
				curY <= (py == V_TOTAL - 1) ? 0 : py + 1;
			end else begin
				curX <= px + 1;
				curY <= py;
			end
			hSyncPrev <= hSync;
			vSyncPrev <= vSync;
		end
	end

	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hLowLen   <= 0;
			hPeriod   <= 0;
			hFallSeen <= 1'b0;
			vLowLen   <= 0;
			vPeriod   <= 0;
			vFallSeen <= 1'b0;
		end else begin
			hLowLen <= hSync ? 0 : hLowLen + 1;
			vLowLen <= vSync ? 0 : vLowLen + 1;
			if (hSyncPrev && !hSync) begin
				hPeriod   <= 1;
				hFallSeen <= 1'b1;
			end else begin
				hPeriod <= hPeriod + 1;
			end
			if (vSyncPrev && !vSync) begin
				vPeriod   <= 1;
				vFallSeen <= 1'b1;
			end else begin
				vPeriod <= vPeriod + 1;
			end
		end
	end

	hSyncWidth: assert property (@(posedge clk) disable iff (!resetN)
		$rose(hSync) |-> (hLowLen == H_SYNC))
	else begin
		hSyncErrors++;
		$display("Error hSync low length: got %h expected %h", $sampled(hLowLen), H_SYNC);
	end

	hSyncPeriod: assert property (@(posedge clk) disable iff (!resetN)
		($fell(hSync) && hFallSeen) |-> (hPeriod == H_TOTAL))
	else begin
		hSyncErrors++;
		$display("Error hSync period: got %h expected %h", $sampled(hPeriod), H_TOTAL);
	end

	vSyncWidth: assert property (@(posedge clk) disable iff (!resetN)
		$rose(vSync) |-> (vLowLen == V_SYNC * H_TOTAL))
	else begin
		vSyncErrors++;
		$display("Error vSync low length: got %h expected %h", $sampled(vLowLen),
			V_SYNC * H_TOTAL);
	end

	vSyncPeriod: assert property (@(posedge clk) disable iff (!resetN)
		($fell(vSync) && vFallSeen) |-> (vPeriod == FRAME_CLOCKS))
	else begin
		vSyncErrors++;
		$display("Error vSync period: got %h expected %h", $sampled(vPeriod), FRAME_CLOCKS);
	end

	blankIsBlack: assert property (@(posedge clk) disable iff (!resetN)
		(locked && !refVisible) |-> (rgbOut == 24'h000000))
	else begin
		blankErrors++;
		$display("Error rgbOut in blanking at x=%0d y=%0d: got %h expected %h",
			$sampled(curX), $sampled(curY), $sampled(rgbOut), 24'h000000);
	end

	visibleColour: assert property (@(posedge clk) disable iff (!resetN)
		refVisible |-> (rgbOut == expectedRgb))
	else begin
		colourErrors++;
		$display("Error rgbOut at x=%0d y=%0d: got %h expected %h",
			$sampled(curX), $sampled(curY), $sampled(rgbOut), $sampled(expectedRgb));
	end

	colourExpansion: assert property (@(posedge clk) disable iff (!resetN)
		refVisible |-> expansionOk(rgbOut))
	else begin
		expansionErrors++;
		$display("Error rgbOut low bits at x=%0d y=%0d: got %h",
			$sampled(curX), $sampled(curY), $sampled(rgbOut));
	end

	task automatic waitForFrameStart(output logic found);
		int cycles;
		found  = 1'b0;
		cycles = 0;
		while (!found && cycles < FRAME_TIMEOUT) begin
			@(posedge clk);
			cycles++;
			if (vSyncPrev && !vSync)
				found = 1'b1;
		end
		if (!found)
			$display("Timed out waiting for a falling edge of vSync");
	endtask

	// new boxes, the player mostly overlapping the prize
	task automatic pickPositions();
		int zx;
		int zy;
		int px;
		int py;
		zx = int'($urandom_range(H_VISIBLE - 16, 0));
		zy = int'($urandom_range(V_VISIBLE - 16, 0));
		if ($urandom_range(3, 0) != 0) begin
			px = zx - 24 + int'($urandom_range(23, 0));
			py = zy - 24 + int'($urandom_range(23, 0));
		end else begin
			px = int'($urandom_range(H_VISIBLE - 32, 0));
			py = int'($urandom_range(V_VISIBLE - 32, 0));
		end
		px = (px < 0) ? 0 : (px > H_VISIBLE - 32) ? H_VISIBLE - 32 : px;
		py = (py < 0) ? 0 : (py > V_VISIBLE - 32) ? V_VISIBLE - 32 : py;
		prizeX  <= COORD_WIDTH'(zx);
		prizeY  <= COORD_WIDTH'(zy);
		playerX <= COORD_WIDTH'(px);
		playerY <= COORD_WIDTH'(py);
	endtask

	initial begin
		logic found;
		logic timedOut;
		int   frame;
		int   totalErrors;
		void'($urandom(94085));
		resetN          = 1'b0;
		playerX         = 10'd100;
		playerY         = 10'd100;
		prizeX          = 10'd300;
		prizeY          = 10'd200;
		hSyncErrors     = 0;
		vSyncErrors     = 0;
		blankErrors     = 0;
		colourErrors    = 0;
		expansionErrors = 0;
		timedOut        = 1'b0;
		repeat (8) @(posedge clk);
		resetN <= 1'b1;
		// one extra frame start so the last moved frame gets checked
		for (frame = 0; frame <= FRAMES && !timedOut; frame++) begin
			waitForFrameStart(found);
			if (!found)
				timedOut = 1'b1;
			else if (frame < FRAMES)
				pickPositions();
		end
		totalErrors = hSyncErrors + vSyncErrors + blankErrors + colourErrors +
			expansionErrors;
		$display("Summary: hSync %0d, vSync %0d, blank %0d, colour %0d, expansion %0d errors",
			hSyncErrors, vSyncErrors, blankErrors, colourErrors, expansionErrors);
		if (timedOut || totalErrors != 0) begin
			$display("Checks failed");
		end else begin
			$display("All checks passed");
		end
		$finish;
	end

endmodule
